// ==== build.f ====
+incdir+verilog
verilog/ir_pkg.sv
verilog/ir_input_filter.sv
verilog/ir_key_decoder.sv
verilog/ir_key_regs.sv
verilog/ir_remote_top.sv
sim/tb_clock_gen.sv
sim/tb_ir_remote.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the IR remote testbench with Verilator.
verilator --binary --timing --assert -Wno-fatal -f build.f \
   --top-module tb_ir_remote -o tb_ir_remote > build.log 2>&1 \
   || { echo "Verilator build failed, see build.log"; exit 1; }
./obj_dir/tb_ir_remote > sim.log 2>&1
cat sim.log
grep -q "TESTBENCH FAILED" sim.log && { echo "Simulation reported failure"; exit 1; }
grep -q "TESTBENCH PASSED" sim.log \
   || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation done"

// ==== sim/tb_clock_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen #(
   parameter int PERIOD_NS    = 40,
   parameter int RESET_CYCLES = 3,
   parameter int DRIVE_DELAY  = 5
) (
   output logic clk,
   output logic reset
);

   initial begin
      clk = 1'b0;
      forever #(PERIOD_NS / 2) clk = ~clk;
   end

   // Released just after an edge, like the other stimulus.
   initial begin
      reset = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk);
      #DRIVE_DELAY;
      reset = 1'b0;
   end

endmodule

`default_nettype wire

// ==== sim/tb_ir_remote.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "ir_config.svh"

module tb_ir_remote
   import ir_pkg::*;
();

   localparam int DRIVE_DELAY    = 5;
   localparam int FRAME_LEN      = 260;
   localparam int FRAME_GAP      = `IR_T_IGNORE + 20;
   localparam int LED_DELAY      = 2 + `IR_FILTER_LEN + 1;
   localparam int TIMEOUT_CYCLES = 12 * (`IR_T_IGNORE + 1000);
   localparam int WAIT_LIMIT     = 2000;
   localparam int ACK_LIMIT      = 16;
   localparam int LED_OFF        = 0;
   localparam int LED_FOLLOW     = 1;
   localparam int LED_LOW        = 2;

   logic        clk;
   logic        reset;
   logic        infrared = 1'b0;
   logic        led;
   logic [3:0]  key_lines;
   logic        wb_cyc = 1'b0;
   logic        wb_stb = 1'b0;
   logic        wb_we = 1'b0;
   logic [1:0]  wb_adr = 2'd0;
   logic [31:0] wb_dat_w = 32'd0;
   logic [31:0] wb_dat_r;
   logic        wb_ack;

   int                 mismatches = 0;
   int                 other_errors = 0;
   int                 cycle_cnt = 0;
   int                 led_mode = LED_OFF;
   int                 high_run = 0;
   int                 last_run = 0;
   int                 runs_done = 0;
   int                 exp_count [4] = '{0, 0, 0, 0};
   logic [31:0]        rng = 32'ha1e6;
   logic [3:0]         allowed_line = 4'd0;
   logic [LED_DELAY:0] ir_hist = '0;
   ir_key_t            exp_last = KEY_1;
   logic               exp_pending = 1'b0;
   logic               checks_on = 1'b0;

   tb_clock_gen i_clock (
      .clk   (clk),
      .reset (reset)
   );

   ir_remote_top i_dut (
      .clk       (clk),
      .reset     (reset),
      .infrared  (infrared),
      .led       (led),
      .key_lines (key_lines),
      .wb_cyc    (wb_cyc),
      .wb_stb    (wb_stb),
      .wb_we     (wb_we),
      .wb_adr    (wb_adr),
      .wb_dat_w  (wb_dat_w),
      .wb_dat_r  (wb_dat_r),
      .wb_ack    (wb_ack)
   );

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Checks and reference model.
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                              input string what);
      if (actual !== expected) begin
         mismatches++;
         $display("MISMATCH at %0t ns: %s, got %0h, expected %0h",
                  $time, what, actual, expected);
      end
   endtask

   task automatic report_error(input string what);
      other_errors++;
      $display("ERROR at %0t ns: %s", $time, what);
   endtask

   function automatic logic [31:0] lcg_next(input logic [31:0] state);
      return state * 32'd1664525 + 32'd1013904223;
   endfunction

   function automatic logic [3:0] ref_line(input ir_key_t key);
      case (key)
         KEY_1:   return 4'b0001;
         KEY_2:   return 4'b0010;
         KEY_3:   return 4'b0100;
         default: return 4'b1000;
      endcase
   endfunction

   // Line is up from the second sample through count T_HOLD - 1.
   function automatic int ref_hold_cycles(input ir_key_t key);
      if (key == KEY_1 || key == KEY_4) begin
         return `IR_T_HOLD - `IR_T_SAMPLE14;
      end
      return `IR_T_HOLD - `IR_T_SAMPLE23;
   endfunction

   function automatic logic [31:0] ref_reg(input ir_reg_addr_t addr);
      case (addr)
         REG_STATUS:   return {29'd0, exp_pending, exp_last};
         REG_COUNT_LO: return {16'd0, 8'(exp_count[1]), 8'(exp_count[0])};
         REG_COUNT_HI: return {16'd0, 8'(exp_count[3]), 8'(exp_count[2])};
         default:      return 32'd0;
      endcase
   endfunction

   // First sample lands near w = 131, the second near w = 191 or 171.
   function automatic logic wave_level(input ir_key_t key, input int w);
      case (key)
         KEY_1:   return w < 160;
         KEY_2:   return w < 100;
         KEY_3:   return (w < 100) || (w >= 150 && w < 200);
         default: return w < 220;
      endcase
   endfunction

   always @(posedge clk) begin
      cycle_cnt = cycle_cnt + 1;
      if (cycle_cnt >= TIMEOUT_CYCLES) begin
         $display("ERROR: run did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("TESTBENCH FAILED");
         $finish;
      end
   end

   // Outputs are compared at the falling edge.
   always @(negedge clk) begin
      ir_hist = {ir_hist[LED_DELAY-1:0], infrared};
      if (checks_on && !reset) begin
         if (key_lines != 4'd0) begin
            check_value(32'(key_lines), 32'(allowed_line), "key lines");
            high_run++;
         end else if (high_run != 0) begin
            last_run = high_run;
            high_run = 0;
            runs_done++;
         end
         if (led_mode == LED_FOLLOW) begin
            check_value(32'(led), 32'(ir_hist[LED_DELAY]), "led follows infrared");
         end else if (led_mode == LED_LOW) begin
            check_value(32'(led), 32'd0, "led stays low");
         end
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Stimulus.
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   task automatic tick();
      @(posedge clk);
      #DRIVE_DELAY;
   endtask

   task automatic wb_access(input logic we, input ir_reg_addr_t addr,
                            input logic [31:0] wdata, output logic [31:0] rdata);
      int waited;
      waited = 0;
      wb_cyc   = 1'b1;
      wb_stb   = 1'b1;
      wb_we    = we;
      wb_adr   = addr;
      wb_dat_w = wdata;
      tick();
      while (!wb_ack && waited < ACK_LIMIT) begin
         tick();
         waited++;
      end
      if (!wb_ack) begin
         report_error($sformatf("no Wishbone ack at offset %0d", addr));
      end
      rdata  = wb_dat_r;
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we  = 1'b0;
   endtask

   task automatic read_check(input ir_reg_addr_t addr, input string what);
      logic [31:0] data;
      wb_access(1'b0, addr, 32'd0, data);
      check_value(data, ref_reg(addr), what);
   endtask

   task automatic clear_counts();
      logic [31:0] unused;
      wb_access(1'b1, REG_CLEAR, 32'd0, unused);
      exp_count   = '{0, 0, 0, 0};
      exp_pending = 1'b0;
      read_check(REG_COUNT_LO, "low counters after clear");
      read_check(REG_COUNT_HI, "high counters after clear");
   endtask

   task automatic send_waveform(input ir_key_t key);
      for (int w = 0; w < FRAME_LEN; w++) begin
         infrared = wave_level(key, w);
         tick();
      end
      infrared = 1'b0;
   endtask

   // Two-cycle pulses on an idle line.
   task automatic send_glitches(input int count);
      int gap;
      led_mode = LED_LOW;
      for (int n = 0; n < count; n++) begin
         rng = lcg_next(rng);
         gap = 12 + int'(rng[19:16]);
         repeat (gap) tick();
         infrared = 1'b1;
         tick();
         tick();
         infrared = 1'b0;
      end
      repeat (12) tick();
      led_mode = LED_FOLLOW;
   endtask

   task automatic press_key(input ir_key_t key, input logic send_repeat,
                            input ir_key_t repeat_key);
      int start;
      int runs_before;
      int waited;
      start        = cycle_cnt;
      runs_before  = runs_done;
      waited       = 0;
      allowed_line = ref_line(key);
      send_waveform(key);
      while (runs_done == runs_before && waited < WAIT_LIMIT) begin
         tick();
         waited++;
      end
      if (runs_done == runs_before) begin
         report_error($sformatf("key line for key %0d never went high", key));
      end else begin
         check_value(32'(last_run), 32'(ref_hold_cycles(key)), "key line hold length");
      end
      allowed_line = 4'd0;
      if (exp_count[int'(key)] < 255) begin
         exp_count[int'(key)]++;
      end
      exp_last    = key;
      exp_pending = 1'b1;
      read_check(REG_STATUS, "status after key");
      exp_pending = 1'b0;
      read_check(REG_STATUS, "status on second read");
      // Still inside the ignore window.
      if (send_repeat) begin
         send_waveform(repeat_key);
         read_check(REG_STATUS, "status after ignored repeat");
      end
      while (cycle_cnt - start < FRAME_GAP) begin
         tick();
      end
   endtask

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Test sequence.
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   initial begin
      ir_key_t key;
      ir_key_t repeat_key;
      @(negedge reset);
      checks_on = 1'b1;
      led_mode  = LED_LOW;
      check_value(32'(key_lines), 32'd0, "key lines after reset");
      read_check(REG_STATUS, "status after reset");
      read_check(REG_COUNT_LO, "low counters after reset");
      read_check(REG_COUNT_HI, "high counters after reset");
      led_mode = LED_FOLLOW;

      for (int i = 0; i < 4; i++) begin
         press_key(ir_key_t'(2'(i)), 1'b0, KEY_1);
      end

      send_glitches(8);
      read_check(REG_STATUS, "status after glitches");
      read_check(REG_COUNT_LO, "low counters after glitches");
      read_check(REG_COUNT_HI, "high counters after glitches");
      clear_counts();

      // Random keys with one repeat inside the ignore window.
      for (int n = 0; n < 8; n++) begin
         rng = lcg_next(rng);
         key = ir_key_t'(rng[17:16]);
         rng = lcg_next(rng);
         repeat_key = ir_key_t'(rng[17:16]);
         send_glitches(2);
         press_key(key, n == 3, repeat_key);
      end
      read_check(REG_COUNT_LO, "low counters after random keys");
      read_check(REG_COUNT_HI, "high counters after random keys");
      clear_counts();

      $display("Checks finished: %0d mismatches, %0d other errors",
               mismatches, other_errors);
      if (mismatches == 0 && other_errors == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== verilog/ir_config.svh ====
`ifndef IR_CONFIG_SVH
`define IR_CONFIG_SVH

// Cycles a new level must hold in the glitch filter.
`define IR_FILTER_LEN 4

// Decoder sample points counted from the frame start.
`define IR_T_SAMPLE1  130
`define IR_T_SAMPLE14 190
`define IR_T_SAMPLE23 170

// Key line hold time.
`define IR_T_HOLD     950

// Repeats are ignored until this count.
`define IR_T_IGNORE   57000

// Wide enough for the ignore window.
`define IR_CNT_W      17

`endif

// ==== verilog/ir_input_filter.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "ir_config.svh"

module ir_input_filter (
   input  logic clk,
   input  logic reset,
   input  logic infrared,
   output logic ir_clean,
   output logic led
);

   localparam int FLT_W = $clog2(`IR_FILTER_LEN + 1);
   localparam logic [FLT_W-1:0] FLT_LAST = FLT_W'(`IR_FILTER_LEN - 1);

   logic             sync_1;
   logic             sync_2;
   logic [FLT_W-1:0] stable_cnt;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Synchronizer.
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   always_ff @(posedge clk) begin
      if (reset) begin
         sync_1 <= 1'b0;
         sync_2 <= 1'b0;
      end else begin
         sync_1 <= infrared;
         sync_2 <= sync_1;
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Glitch filter.
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // A differing level must be seen on FILTER_LEN
   // consecutive samples before it is taken.
   always_ff @(posedge clk) begin
      if (reset) begin
         stable_cnt <= '0;
         ir_clean   <= 1'b0;
      end else if (sync_2 == ir_clean) begin
         stable_cnt <= '0;
      end else if (stable_cnt == FLT_LAST) begin
         stable_cnt <= '0;
         ir_clean   <= sync_2;
      end else begin
         stable_cnt <= stable_cnt + 1'b1;
      end
   end

   // Activity LED.
   always_ff @(posedge clk) begin
      if (reset) begin
         led <= 1'b0;
      end else begin
         led <= ir_clean;
      end
   end

endmodule

`default_nettype wire

// ==== verilog/ir_key_decoder.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "ir_config.svh"

module ir_key_decoder
   import ir_pkg::*;
(
   input  logic       clk,
   input  logic       reset,
   input  logic       ir_clean,
   output logic [3:0] key_lines,
   output logic       key_valid,
   output ir_key_t    key_code
);

   localparam int CNT_W = `IR_CNT_W;

   localparam logic [CNT_W-1:0] T_SAMPLE1  = CNT_W'(`IR_T_SAMPLE1);
   localparam logic [CNT_W-1:0] T_SAMPLE14 = CNT_W'(`IR_T_SAMPLE14);
   localparam logic [CNT_W-1:0] T_SAMPLE23 = CNT_W'(`IR_T_SAMPLE23);
   localparam logic [CNT_W-1:0] T_HOLD     = CNT_W'(`IR_T_HOLD);
   localparam logic [CNT_W-1:0] T_IGNORE   = CNT_W'(`IR_T_IGNORE);

   ir_dec_state_t    state;
   ir_dec_state_t    next_state;
   logic [CNT_W-1:0] frame_cnt;
   ir_key_t          held_key;
   ir_key_t          decoded_key;
   ir_key_t          line_key;
   logic             hold_active;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // State and frame counter.
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   always_ff @(posedge clk) begin
      if (reset) begin
         state     <= ST_IDLE;
         frame_cnt <= '0;
      end else begin
         state <= next_state;
         // Frame count runs from the first cycle after leaving idle.
         if (state == ST_IDLE) begin
            frame_cnt <= '0;
         end else begin
            frame_cnt <= frame_cnt + 1'b1;
         end
      end
   end

   always_comb begin
      next_state = state;
      case (state)
         ST_IDLE: begin
            if (ir_clean) begin
               next_state = ST_PRESS;
            end
         end
         ST_PRESS: begin
            if (frame_cnt >= T_SAMPLE1) begin
               next_state = ir_clean ? ST_GROUP_14 : ST_GROUP_23;
            end
         end
         ST_GROUP_14: begin
            if (frame_cnt >= T_SAMPLE14) begin
               next_state = ST_HOLD;
            end
         end
         ST_GROUP_23: begin
            if (frame_cnt >= T_SAMPLE23) begin
               next_state = ST_HOLD;
            end
         end
         ST_HOLD: begin
            if (frame_cnt >= T_IGNORE) begin
               next_state = ST_IDLE;
            end
         end
         default: begin
            next_state = ST_IDLE;
         end
      endcase
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Key decision.
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   always_comb begin
      if (state == ST_GROUP_23) begin
         decoded_key = ir_clean ? KEY_3 : KEY_2;
      end else begin
         decoded_key = ir_clean ? KEY_4 : KEY_1;
      end
   end

   assign key_valid = ((state == ST_GROUP_14) && (frame_cnt >= T_SAMPLE14)) ||
                      ((state == ST_GROUP_23) && (frame_cnt >= T_SAMPLE23));

   assign key_code = decoded_key;

   always_ff @(posedge clk) begin
      if (key_valid) begin
         held_key <= decoded_key;
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Key lines.
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Line rises with the strobe and is then held from the register.
   assign hold_active = (state == ST_HOLD) && (frame_cnt < T_HOLD);
   assign line_key    = key_valid ? decoded_key : held_key;

   always_comb begin
      if (key_valid || hold_active) begin
         key_lines = 4'b0001 << line_key;
      end else begin
         key_lines = 4'b0000;
      end
   end

   // A held line keeps the key raised by the strobe.
   a_line_held: assert property (
      @(posedge clk) disable iff (reset)
      (key_lines != 4'd0) && !key_valid |-> key_lines == $past(key_lines)
   );

   // One strobe per frame.
   a_valid_single: assert property (
      @(posedge clk) disable iff (reset)
      key_valid |=> !key_valid
   );

endmodule

`default_nettype wire

// ==== verilog/ir_key_regs.sv ====
`timescale 1ns/1ns
`default_nettype none

module ir_key_regs
   import ir_pkg::*;
(
   input  logic        clk,
   input  logic        reset,
   input  logic        key_valid,
   input  ir_key_t     key_code,
   input  logic        wb_cyc,
   input  logic        wb_stb,
   input  logic        wb_we,
   input  logic [1:0]  wb_adr,
   input  logic [31:0] wb_dat_w,
   output logic [31:0] wb_dat_r,
   output logic        wb_ack
);

   ir_key_t      last_key;
   logic         pending;
   logic [7:0]   key_count [4];
   logic         access;
   ir_reg_addr_t reg_sel;
   logic         status_read;
   logic         status_w1c;
   logic         clear_write;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Bus decode.
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   assign access      = wb_cyc && wb_stb && !wb_ack;
   assign reg_sel     = ir_reg_addr_t'(wb_adr);
   assign status_read = access && !wb_we && (reg_sel == REG_STATUS);
   // Writing a one to the pending bit also drops it.
   assign status_w1c  = access && wb_we && (reg_sel == REG_STATUS) && wb_dat_w[2];
   assign clear_write = access && wb_we && (reg_sel == REG_CLEAR);

   always_ff @(posedge clk) begin
      if (reset) begin
         wb_ack <= 1'b0;
      end else begin
         wb_ack <= access;
      end
   end

   always_ff @(posedge clk) begin
      if (access) begin
         case (reg_sel)
            REG_STATUS:   wb_dat_r <= {29'd0, pending, last_key};
            REG_COUNT_LO: wb_dat_r <= {16'd0, key_count[1], key_count[0]};
            REG_COUNT_HI: wb_dat_r <= {16'd0, key_count[3], key_count[2]};
            default:      wb_dat_r <= 32'd0;
         endcase
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Key state.
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // A new key beats any clear in the same cycle.
   always_ff @(posedge clk) begin
      if (reset) begin
         last_key <= KEY_1;
         pending  <= 1'b0;
      end else if (key_valid) begin
         last_key <= key_code;
         pending  <= 1'b1;
      end else if (status_read || status_w1c || clear_write) begin
         pending  <= 1'b0;
      end
   end

   // Saturating press counters.
   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < 4; i++) begin
            key_count[i] <= 8'd0;
         end
      end else begin
         for (int i = 0; i < 4; i++) begin
            if (key_valid && (key_code == ir_key_t'(i))) begin
               if (key_count[i] != 8'hff) begin
                  key_count[i] <= key_count[i] + 8'd1;
               end
            end else if (clear_write) begin
               key_count[i] <= 8'd0;
            end
         end
      end
   end

   a_ack_single: assert property (
      @(posedge clk) disable iff (reset)
      wb_ack |=> !wb_ack
   );

endmodule

`default_nettype wire

// ==== verilog/ir_pkg.sv ====
`default_nettype none

package ir_pkg;

   typedef enum logic [1:0] {
      KEY_1 = 2'd0,
      KEY_2 = 2'd1,
      KEY_3 = 2'd2,
      KEY_4 = 2'd3
   } ir_key_t;

   typedef enum logic [2:0] {
      ST_IDLE,
      ST_PRESS,
      ST_GROUP_14,
      ST_GROUP_23,
      ST_HOLD
   } ir_dec_state_t;

   // Wishbone register offsets.
   typedef enum logic [1:0] {
      REG_STATUS   = 2'd0,
      REG_COUNT_LO = 2'd1,
      REG_COUNT_HI = 2'd2,
      REG_CLEAR    = 2'd3
   } ir_reg_addr_t;

endpackage

`default_nettype wire

// ==== verilog/ir_remote_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module ir_remote_top
   import ir_pkg::*;
(
   input  logic        clk,
   input  logic        reset,
   input  logic        infrared,
   output logic        led,
   output logic [3:0]  key_lines,
   input  logic        wb_cyc,
   input  logic        wb_stb,
   input  logic        wb_we,
   input  logic [1:0]  wb_adr,
   input  logic [31:0] wb_dat_w,
   output logic [31:0] wb_dat_r,
   output logic        wb_ack
);

   logic    ir_clean;
   logic    key_valid;
   ir_key_t key_code;

   ir_input_filter i_filter (
      .clk      (clk),
      .reset    (reset),
      .infrared (infrared),
      .ir_clean (ir_clean),
      .led      (led)
   );

   ir_key_decoder i_decoder (
      .clk       (clk),
      .reset     (reset),
      .ir_clean  (ir_clean),
      .key_lines (key_lines),
      .key_valid (key_valid),
      .key_code  (key_code)
   );

   ir_key_regs i_regs (
      .clk       (clk),
      .reset     (reset),
      .key_valid (key_valid),
      .key_code  (key_code),
      .wb_cyc    (wb_cyc),
      .wb_stb    (wb_stb),
      .wb_we     (wb_we),
      .wb_adr    (wb_adr),
      .wb_dat_w  (wb_dat_w),
      .wb_dat_r  (wb_dat_r),
      .wb_ack    (wb_ack)
   );

endmodule

`default_nettype wire
